// File: riscvPkg.sv
package riscvPkg;

    localparam int xlen = 32; // data word width

    // R-type view, also used for opcode/funct fields of every format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeFields_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeFields_t;

    typedef union packed {
        rTypeFields_t       rType;
        iTypeFields_t       iType;
        logic [xlen-1:0]    raw; // scattered S/B/J immediates
    } instrWord_u;

    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    localparam logic [2:0] aluAdd = 3'b000;
    localparam logic [2:0] aluSub = 3'b001;
    localparam logic [2:0] aluSll = 3'b110;

    localparam logic [2:0] immI = 3'b000;
    localparam logic [2:0] immS = 3'b001;
    localparam logic [2:0] immB = 3'b010;
    localparam logic [2:0] immJ = 3'b100;

endpackage

// File: controlUnit.sv
`timescale 1ns/1ps

module controlUnit
    import riscvPkg::*;
(
    input  instrWord_u  instr,
    output logic        regWrite,
    output logic        resultSrc,    // load data to write-back
    output logic        memWrite,
    output logic        branch,
    output logic        branchInvert, // bne
    output logic        jump,         // link value to write-back
    output logic        jalrSel,
    output logic        aluSrc,       // imm as second operand
    output logic [2:0]  aluControl,
    output logic [2:0]  immSrc
);

    always_comb
    begin
        regWrite     = 1'b0;
        resultSrc    = 1'b0;
        memWrite     = 1'b0;
        branch       = 1'b0;
        branchInvert = 1'b0;
        jump         = 1'b0;
        jalrSel      = 1'b0;
        aluSrc       = 1'b0;
        aluControl   = aluAdd;
        immSrc       = immI;

        case (instr.rType.opcode)
            opImm:
            begin
                if (instr.rType.funct3 == 3'b000) // addi
                begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                end
                else if (instr.rType.funct3 == 3'b001 && instr.rType.funct7 == 7'b0000000)
                begin
                    regWrite   = 1'b1; // slli
                    aluSrc     = 1'b1;
                    aluControl = aluSll;
                end
            end

            opReg:
            begin
                if (instr.rType.funct3 == 3'b000 && instr.rType.funct7 == 7'b0000000)
                    regWrite = 1'b1; // add
                else if (instr.rType.funct3 == 3'b000 && instr.rType.funct7 == 7'b0100000)
                begin
                    regWrite   = 1'b1; // sub
                    aluControl = aluSub;
                end
            end

            opBranch:
            begin
                if (instr.rType.funct3 == 3'b000 || instr.rType.funct3 == 3'b001)
                begin
                    branch       = 1'b1;
                    branchInvert = instr.rType.funct3[0]; // bne when set
                    immSrc       = immB;
                    aluControl   = aluSub; // compare via zero flag
                end
            end

            opStore:
            begin
                if (instr.rType.funct3 == 3'b010) // sw
                begin
                    memWrite = 1'b1;
                    aluSrc   = 1'b1;
                    immSrc   = immS;
                end
            end

            opLoad:
            begin
                if (instr.rType.funct3 == 3'b010) // lw
                begin
                    regWrite  = 1'b1;
                    resultSrc = 1'b1;
                    aluSrc    = 1'b1;
                end
            end

            opJal:
            begin
                regWrite = 1'b1;
                jump     = 1'b1;
                immSrc   = immJ;
            end

            opJalr:
            begin
                if (instr.rType.funct3 == 3'b000)
                begin
                    regWrite = 1'b1;
                    jump     = 1'b1;
                    jalrSel  = 1'b1;
                    aluSrc   = 1'b1; // target is rs1 + imm from the ALU
                end
            end

            default:
            begin
                regWrite = 1'b0; // unsupported, behaves as a no-op
            end
        endcase
    end

endmodule

// File: immExtend.sv
`timescale 1ns/1ps

module immExtend
    import riscvPkg::*;
(
    input  instrWord_u          instr,
    input  logic [2:0]          immSrc,
    output logic [xlen-1:0]     imm
);

    logic sign;

    assign sign = instr.raw[31]; // immediate sign is always bit 31

    always_comb
    begin
        case (immSrc)
            immI:
                imm = {{20{sign}}, instr.iType.imm};
            immS:
                imm = {{20{sign}}, instr.raw[31:25], instr.raw[11:7]};
            immB:
                imm = {{19{sign}}, instr.raw[31], instr.raw[7],
                       instr.raw[30:25], instr.raw[11:8], 1'b0};
            immJ:
                imm = {{11{sign}}, instr.raw[31], instr.raw[19:12],
                       instr.raw[20], instr.raw[30:21], 1'b0};
            default:
                imm = {{20{sign}}, instr.iType.imm};
        endcase
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile
    import riscvPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic [4:0]          rs1Addr,
    input  logic [4:0]          rs2Addr,
    input  logic [4:0]          writeAddr,
    input  logic                writeEn,
    input  logic [xlen-1:0]     writeData,
    output logic [xlen-1:0]     rs1Data,
    output logic [xlen-1:0]     rs2Data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (writeEn && writeAddr != 5'd0) // x0 stays zero
        begin
            regs[writeAddr] <= writeData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

// File: aluExec.sv
`timescale 1ns/1ps

module aluExec
    import riscvPkg::*;
(
    input  logic [xlen-1:0]     pc,
    input  logic [xlen-1:0]     rs1Data,
    input  logic [xlen-1:0]     rs2Data,
    input  logic [xlen-1:0]     imm,
    input  logic [2:0]          aluControl,
    input  logic                aluSrc,
    input  logic                branch,
    input  logic                branchInvert,
    input  logic                jump,
    input  logic                jalrSel,
    output logic [xlen-1:0]     aluResult,
    output logic [xlen-1:0]     linkValue,
    output logic [xlen-1:0]     nextPc
);

    logic [xlen-1:0] srcB;
    logic            zero;
    logic            takeBranch;

    assign srcB = aluSrc ? imm : rs2Data;

    always_comb
    begin
        case (aluControl)
            aluAdd:  aluResult = rs1Data + srcB;
            aluSub:  aluResult = rs1Data - srcB;
            aluSll:  aluResult = rs1Data << srcB[4:0]; // shamt from low 5 bits
            default: aluResult = '0;
        endcase
    end

    assign zero       = (aluResult == '0);
    assign takeBranch = branch & (zero ^ branchInvert);
    assign linkValue  = pc + 32'd4;

    always_comb
    begin
        if (jalrSel)
            nextPc = {aluResult[xlen-1:1], 1'b0}; // rs1 + imm, bit 0 cleared
        else if (jump || takeBranch)
            nextPc = pc + imm;
        else
            nextPc = linkValue;
    end

endmodule

// File: dataMem.sv
`timescale 1ns/1ps

module dataMem
    import riscvPkg::*;
#(
    parameter int dmemDepth = 256
)(
    input  logic                clk,
    input  logic                writeEn,
    input  logic [xlen-1:0]     addr,
    input  logic [xlen-1:0]     writeData,
    output logic [xlen-1:0]     readData
);

    localparam int addrW = $clog2(dmemDepth);

    logic [xlen-1:0]  mem [dmemDepth];
    logic [addrW-1:0] wordIdx;

    assign wordIdx = addr[addrW+1:2]; // byte address to word index

    always_ff @(posedge clk)
    begin
        if (writeEn)
            mem[wordIdx] <= writeData;
    end

    assign readData = mem[wordIdx];

endmodule

// File: instrMem.sv
`timescale 1ns/1ps

module instrMem
    import riscvPkg::*;
#(
    parameter int imemDepth = 256
)(
    input  logic                clk,
    input  logic                loadEn,
    input  logic [xlen-1:0]     loadAddr, // byte address, like pc
    input  logic [xlen-1:0]     loadData,
    input  logic [xlen-1:0]     pc,
    output instrWord_u          instr
);

    localparam int addrW = $clog2(imemDepth);

    logic [xlen-1:0] mem [imemDepth];

    always_ff @(posedge clk)
    begin
        if (loadEn)
            mem[loadAddr[addrW+1:2]] <= loadData;
    end

    assign instr = mem[pc[addrW+1:2]];

endmodule

// File: riscvCore.sv
`timescale 1ns/1ps

module riscvCore
    import riscvPkg::*;
#(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
)(
    input  logic                clk,
    input  logic                arstN,
    input  logic                run,
    input  logic                loadEn,
    input  logic [xlen-1:0]     loadAddr,
    input  logic [xlen-1:0]     loadData,
    output logic                retire,
    output logic                regWriteEn,
    output logic [4:0]          regWriteAddr,
    output logic [xlen-1:0]     retirePc,
    output logic [xlen-1:0]     regWriteData
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] nextPc;
    instrWord_u      instr;

    logic            regWrite, resultSrc, memWrite;
    logic            branch, branchInvert, jump, jalrSel, aluSrc;
    logic [2:0]      aluControl, immSrc;

    logic [xlen-1:0] rs1Data, rs2Data, imm;
    logic [xlen-1:0] aluResult, linkValue, readData;
    logic [xlen-1:0] writeBack;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pc <= '0;
        else if (run)
            pc <= nextPc; // one instruction per edge
    end

    instrMem #(.imemDepth(imemDepth)) uInstrMem (
        .clk(clk), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .pc(pc), .instr(instr)
    );

    controlUnit uControlUnit (
        .instr(instr), .regWrite(regWrite), .resultSrc(resultSrc), .memWrite(memWrite),
        .branch(branch), .branchInvert(branchInvert), .jump(jump), .jalrSel(jalrSel),
        .aluSrc(aluSrc), .aluControl(aluControl), .immSrc(immSrc)
    );

    regFile uRegFile (
        .clk(clk), .arstN(arstN),
        .rs1Addr(instr.rType.rs1), .rs2Addr(instr.rType.rs2), .writeAddr(instr.rType.rd),
        .writeEn(regWriteEn), .writeData(writeBack),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    immExtend uImmExtend (.instr(instr), .immSrc(immSrc), .imm(imm));

    aluExec uAluExec (
        .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .aluControl(aluControl), .aluSrc(aluSrc), .branch(branch),
        .branchInvert(branchInvert), .jump(jump), .jalrSel(jalrSel),
        .aluResult(aluResult), .linkValue(linkValue), .nextPc(nextPc)
    );

    dataMem #(.dmemDepth(dmemDepth)) uDataMem (
        .clk(clk), .writeEn(memWrite & run), .addr(aluResult),
        .writeData(rs2Data), .readData(readData)
    );

    always_comb
    begin
        if (jump)
            writeBack = linkValue;
        else if (resultSrc)
            writeBack = readData; // lw
        else
            writeBack = aluResult;
    end

    assign retire       = run;
    assign retirePc     = pc;
    assign regWriteEn   = regWrite & run; // no writes while stopped
    assign regWriteAddr = instr.rType.rd;
    assign regWriteData = writeBack;

endmodule

// File: tbPrograms.svh
task automatic testResetState;
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd1));
    prog.push_back(addi(5'd2, 5'd0, 12'd2));
    runProgram;
    nextRetire(32'd0, 1'b1);
    expectWriteBack(5'd1, 32'd1);
    nextRetire(32'd4, 1'b1);
    expectWriteBack(5'd2, 32'd2);
    stopRun;
    pulseReset; // pc had moved on, word 0 is a register write
    #(clkPeriod / 4);
    checkBit("retire", retire, 1'b0);
    checkBit("regWriteEn", regWriteEn, 1'b0);
    checkWord("retirePc", retirePc, '0);
endtask

task automatic testImmediate;
    logic [11:0]     immA;
    logic [11:0]     immB;
    logic [4:0]      shamt;
    logic [xlen-1:0] valA;
    drawImm(immA);
    drawImm(immB);
    shamt = immB[4:0];
    valA  = sext12(immA);
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, immA));
    prog.push_back(slli(5'd2, 5'd1, shamt));
    prog.push_back(addi(5'd0, 5'd1, 12'd5)); // x0 target, value is dropped
    prog.push_back(add(5'd3, 5'd0, 5'd0));   // x0 must read back as zero
    runProgram;
    nextRetire(32'd0, 1'b1);
    expectWriteBack(5'd1, valA);
    nextRetire(32'd4, 1'b1);
    expectWriteBack(5'd2, valA << shamt);
    nextRetire(32'd8, 1'b1);
    expectWriteBack(5'd0, valA + 32'd5);
    nextRetire(32'd12, 1'b1);
    expectWriteBack(5'd3, 32'd0);
    stopRun;
endtask

task automatic testRegReg;
    logic [11:0]     immA;
    logic [11:0]     immB;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    drawImm(immA);
    drawImm(immB);
    a = sext12(immA);
    b = sext12(immB);
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, immA));
    prog.push_back(addi(5'd2, 5'd0, immB));
    prog.push_back(add(5'd3, 5'd1, 5'd2));
    prog.push_back(sub(5'd4, 5'd1, 5'd2));
    prog.push_back(sub(5'd5, 5'd2, 5'd1)); // one of the two wraps
    runProgram;
    nextRetire(32'd0, 1'b1);
    expectWriteBack(5'd1, a);
    nextRetire(32'd4, 1'b1);
    expectWriteBack(5'd2, b);
    nextRetire(32'd8, 1'b1);
    expectWriteBack(5'd3, a + b);
    nextRetire(32'd12, 1'b1);
    expectWriteBack(5'd4, a - b);
    nextRetire(32'd16, 1'b1);
    expectWriteBack(5'd5, b - a);
    stopRun;
endtask

task automatic testMemory;
    logic [11:0] immA;
    drawImm(immA);
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, immA));
    prog.push_back(addi(5'd2, 5'd0, 12'd16)); // base address
    prog.push_back(sw(5'd1, 5'd2, 12'd8));
    prog.push_back(lw(5'd3, 5'd2, 12'd8));
    runProgram;
    nextRetire(32'd0, 1'b1);
    expectWriteBack(5'd1, sext12(immA));
    nextRetire(32'd4, 1'b1);
    expectWriteBack(5'd2, 32'd16);
    nextRetire(32'd8, 1'b0);
    nextRetire(32'd12, 1'b1);
    expectWriteBack(5'd3, sext12(immA));
    stopRun;
endtask

task automatic testBranches;
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd7));
    prog.push_back(addi(5'd2, 5'd0, 12'd7));
    prog.push_back(branchWord(3'b000, 5'd1, 5'd2, 13'd12)); // beq taken
    prog.push_back(addi(5'd3, 5'd0, 12'd1));
    prog.push_back(addi(5'd0, 5'd0, 12'd0));
    prog.push_back(branchWord(3'b001, 5'd1, 5'd2, 13'd8));  // bne not taken
    prog.push_back(branchWord(3'b000, 5'd1, 5'd0, 13'd8));  // beq not taken
    prog.push_back(branchWord(3'b001, 5'd1, 5'd0, -13'd16)); // bne taken, backwards
    runProgram;
    nextRetire(32'd0, 1'b1);
    expectWriteBack(5'd1, 32'd7);
    nextRetire(32'd4, 1'b1);
    expectWriteBack(5'd2, 32'd7);
    nextRetire(32'd8, 1'b0);
    nextRetire(32'd8 + 32'd12, 1'b0);
    nextRetire(32'd20 + 32'd4, 1'b0);
    nextRetire(32'd24 + 32'd4, 1'b0);
    nextRetire(32'd28 - 32'd16, 1'b1);
    expectWriteBack(5'd3, 32'd1);
    stopRun;
endtask

task automatic testJumps;
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd40));
    prog.push_back(jal(5'd5, 21'd12));
    prog.push_back(addi(5'd0, 5'd0, 12'd0));
    prog.push_back(addi(5'd0, 5'd0, 12'd0));
    prog.push_back(jalr(5'd6, 5'd1, 12'd5)); // odd target, bit 0 dropped
    while (prog.size() < 11)
        prog.push_back(addi(5'd0, 5'd0, 12'd0));
    prog.push_back(addi(5'd7, 5'd0, 12'd1));
    runProgram;
    nextRetire(32'd0, 1'b1);
    expectWriteBack(5'd1, 32'd40);
    nextRetire(32'd4, 1'b1);
    expectWriteBack(5'd5, 32'd4 + 32'd4);
    nextRetire(32'd4 + 32'd12, 1'b1);
    expectWriteBack(5'd6, 32'd16 + 32'd4);
    nextRetire((32'd40 + 32'd5) & ~32'd1, 1'b1);
    expectWriteBack(5'd7, 32'd1);
    stopRun;
endtask

// File: tbRiscvCore.sv
`timescale 1ns/1ps

module tbRiscvCore
    import riscvPkg::*;
();

    localparam int clkPeriod     = 20;
    localparam int imemWords     = 64;
    localparam int dmemWords     = 64;
    localparam int testCount     = 6;
    localparam int cyclesPerTest = 40; // longest program: load, reset and run
    localparam int cycleLimit    = testCount * cyclesPerTest + 100;

    logic            clk = 1'b0;
    logic            arstN;
    logic            run;
    logic            loadEn;
    logic [xlen-1:0] loadAddr;
    logic [xlen-1:0] loadData;
    logic            retire;
    logic            regWriteEn;
    logic [4:0]      regWriteAddr;
    logic [xlen-1:0] retirePc;
    logic [xlen-1:0] regWriteData;

    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;
    int              seed = 32'he314_f676;
    logic            runFresh; // run just raised, first retire is already visible
    logic [xlen-1:0] prog [$];

    riscvCore #(.imemDepth(imemWords), .dmemDepth(dmemWords)) DUT (
        .clk(clk), .arstN(arstN), .run(run), .loadEn(loadEn),
        .loadAddr(loadAddr), .loadData(loadData),
        .retire(retire), .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr),
        .retirePc(retirePc), .regWriteData(regWriteData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycleLimit)
        begin
            $display("Timeout: test sequence still running after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic checkWord(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0d ns %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input logic [4:0] got,
                             input logic [4:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // destination register and value of the current write-back
    task automatic expectWriteBack(input logic [4:0] expRd, input logic [xlen-1:0] expData);
        checkAddr("regWriteAddr", regWriteAddr, expRd);
        checkWord("regWriteData", regWriteData, expData);
    endtask

    // RV32I encoders, field order straight from the ISA formats
    function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] slli(logic [4:0] rd, logic [4:0] rs1, logic [4:0] sh);
        return {7'b0000000, sh, rs1, 3'b001, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] sub(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branchWord(logic [2:0] f3, logic [4:0] rs1,
                                               logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [xlen-1:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic drawImm(output logic [11:0] v);
        logic [31:0] r;
        r = $random(seed);
        v = r[11:0];
    endtask

    task automatic loadProgram;
        foreach (prog[i])
        begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = 4 * i; // byte address of word i
            loadData = prog[i];
        end
        @(negedge clk);
        loadEn = 1'b0;
    endtask

    task automatic pulseReset;
        @(negedge clk);
        arstN = 1'b0;
        repeat (3) @(negedge clk);
        arstN = 1'b1;
    endtask

    task automatic runProgram;
        loadProgram;
        pulseReset;
        @(negedge clk);
        run      = 1'b1;
        runFresh = 1'b1;
    endtask

    task automatic stopRun;
        @(negedge clk);
        run = 1'b0;
    endtask

    // sample a quarter period into the low phase, well before the commit edge
    task automatic nextRetire(input logic [xlen-1:0] expPc, input logic expWen);
        if (!runFresh)
            @(negedge clk);
        runFresh = 1'b0;
        #(clkPeriod / 4);
        checkBit("retire", retire, 1'b1);
        checkWord("retirePc", retirePc, expPc);
        checkBit("regWriteEn", regWriteEn, expWen);
    endtask

    `include "tbPrograms.svh"

    initial
    begin
        arstN    = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        runFresh = 1'b0;
        pulseReset;
        testResetState;
        testImmediate;
        testRegReg;
        testMemory;
        testBranches;
        testJumps;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
riscvPkg.sv
controlUnit.sv
immExtend.sv
regFile.sv
aluExec.sv
dataMem.sv
instrMem.sv
riscvCore.sv
tbRiscvCore.sv

// File: run.sh
#!/bin/sh
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tbRiscvCore -o simv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed!" sim.log; then
    exit 0
fi
exit 1
